// File: hdl/corr_pkg.sv
/* correlator package
   shared widths, bus structs, address map and state encodings */
`default_nettype none

package corr_pkg;

	localparam int ACC_WIDTH = 32; // sums wrap modulo 2**32

	// offset binary, sample in bits 15:2
	typedef struct packed {
		logic [15:0] ch0;
		logic [15:0] ch1;
	} adc_raw_t;

	typedef logic signed [13:0] sample_t;

	typedef struct packed {
		logic [ACC_WIDTH-1:0] aa;
		logic [ACC_WIDTH-1:0] bb;
		logic [ACC_WIDTH-1:0] ab;
	} corr_result_t;

	typedef struct packed {
		logic        capture_en;
		logic        corr_en;
		logic [15:0] acc_len;
	} ctrl_t;

	typedef struct packed {
		logic        psel;
		logic        penable;
		logic        pwrite;
		logic [11:0] paddr;
		logic [31:0] pwdata;
	} apb_req_t;

	typedef struct packed {
		logic [31:0] prdata;
		logic        pready;
		logic        pslverr;
	} apb_rsp_t;

	// register addresses, buffers decoded on paddr[11:10]
	localparam logic [11:0] ADDR_CTRL    = 12'h000;
	localparam logic [11:0] ADDR_ACC_LEN = 12'h004;
	localparam logic [11:0] ADDR_STATUS  = 12'h008;

	typedef enum logic [2:0] {
		REG_CTRL,
		REG_ACC_LEN,
		REG_STATUS,
		SEL_SNAPSHOT,
		SEL_RESULT,
		SEL_NONE
	} reg_sel_e;

	typedef enum logic [1:0] {
		CAP_IDLE,
		CAP_FILL,
		CAP_DONE
	} capture_state_e;

endpackage

`default_nettype wire

// File: hdl/apb_regs.sv
/* apb slave with control and status registers
   buffer reads take one wait state since both buffers read synchronously */
`default_nettype none

module apb_regs #(
	parameter int CAPTURE_DEPTH = 256,
	parameter int RESULT_DEPTH  = 16
) (
	input  wire                                  data_clk_div,
	input  wire                                  reset,
	input  wire corr_pkg::apb_req_t              apb_req,
	output corr_pkg::apb_rsp_t                   apb_rsp,
	output corr_pkg::ctrl_t                      ctrl,
	input  wire                                  capture_done,
	input  wire [7:0]                            result_count,
	output logic [$clog2(CAPTURE_DEPTH)-1:0]     snap_raddr,
	output logic                                 snap_re,
	input  wire corr_pkg::adc_raw_t              snap_rdata,
	output logic [$clog2(RESULT_DEPTH)+1:0]      res_raddr,
	output logic                                 res_re,
	input  wire [31:0]                           res_rdata
);

	localparam int SNAP_AW = $clog2(CAPTURE_DEPTH);
	localparam int RES_EW  = $clog2(RESULT_DEPTH);

	corr_pkg::reg_sel_e sel;
	logic access;
	logic buf_read;
	logic illegal;
	logic wait_q; // second access cycle of a buffer read
	logic wr_en;

	// address decode, unaligned addresses fall to SEL_NONE
	always_comb begin
		sel = corr_pkg::SEL_NONE;
		if (apb_req.paddr[1:0] == 2'b00) begin
			if (apb_req.paddr == corr_pkg::ADDR_CTRL)
				sel = corr_pkg::REG_CTRL;
			else if (apb_req.paddr == corr_pkg::ADDR_ACC_LEN)
				sel = corr_pkg::REG_ACC_LEN;
			else if (apb_req.paddr == corr_pkg::ADDR_STATUS)
				sel = corr_pkg::REG_STATUS;
			else if (apb_req.paddr[11:10] == 2'b01)
				sel = corr_pkg::SEL_SNAPSHOT;
			else if (apb_req.paddr[11:10] == 2'b10)
				sel = corr_pkg::SEL_RESULT;
		end
	end

	assign access   = apb_req.psel & apb_req.penable;
	assign buf_read = !apb_req.pwrite &&
		(sel == corr_pkg::SEL_SNAPSHOT || sel == corr_pkg::SEL_RESULT);
	assign illegal  = (sel == corr_pkg::SEL_NONE) || (apb_req.pwrite &&
		(sel == corr_pkg::REG_STATUS || sel == corr_pkg::SEL_SNAPSHOT ||
		sel == corr_pkg::SEL_RESULT));
	assign wr_en    = access & apb_req.pwrite & !illegal;

	always_ff @(posedge data_clk_div) begin
		if (reset)
			wait_q <= 1'b0;
		else
			wait_q <= access & buf_read & !wait_q;
	end

	// buffer read ports, issued in the first access cycle
	assign snap_re    = access & (sel == corr_pkg::SEL_SNAPSHOT) & !apb_req.pwrite & !wait_q;
	assign snap_raddr = apb_req.paddr[2 +: SNAP_AW];
	assign res_re     = access & (sel == corr_pkg::SEL_RESULT) & !apb_req.pwrite & !wait_q;
	assign res_raddr  = {apb_req.paddr[4 +: RES_EW], apb_req.paddr[3:2]}; // entry, word

	always_ff @(posedge data_clk_div) begin
		if (reset) begin
			ctrl.capture_en <= 1'b0;
			ctrl.corr_en    <= 1'b0;
			ctrl.acc_len    <= 16'd1;
		end else if (wr_en) begin
			if (sel == corr_pkg::REG_CTRL) begin
				ctrl.capture_en <= apb_req.pwdata[0];
				ctrl.corr_en    <= apb_req.pwdata[1];
			end
			if (sel == corr_pkg::REG_ACC_LEN)
				ctrl.acc_len <= apb_req.pwdata[15:0];
		end
	end

	always_comb begin
		apb_rsp.pready  = access & (!buf_read | wait_q);
		apb_rsp.pslverr = apb_rsp.pready & illegal;
		apb_rsp.prdata  = '0;
		if (!apb_req.pwrite) begin
			case (sel)
				corr_pkg::REG_CTRL:     apb_rsp.prdata = {30'd0, ctrl.corr_en, ctrl.capture_en};
				corr_pkg::REG_ACC_LEN:  apb_rsp.prdata = {16'd0, ctrl.acc_len};
				corr_pkg::REG_STATUS:   apb_rsp.prdata = {16'd0, result_count, 7'd0, capture_done};
				corr_pkg::SEL_SNAPSHOT: apb_rsp.prdata = snap_rdata;
				corr_pkg::SEL_RESULT:   apb_rsp.prdata = res_rdata;
				default:                apb_rsp.prdata = '0;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: hdl/snapshot_capture.sv
/* snapshot capture of raw adc pairs
   fills the buffer with the next valid samples once capture is armed */
`default_nettype none

module snapshot_capture #(
	parameter int CAPTURE_DEPTH = 256
) (
	input  wire                                 data_clk_div,
	input  wire                                 reset,
	input  wire                                 capture_en,
	input  wire corr_pkg::adc_raw_t             adc_in,
	input  wire                                 adc_valid,
	output logic                                capture_done,
	input  wire [$clog2(CAPTURE_DEPTH)-1:0]     snap_raddr,
	input  wire                                 snap_re,
	output corr_pkg::adc_raw_t                  snap_rdata
);

	localparam int AW = $clog2(CAPTURE_DEPTH);
	localparam logic [AW-1:0] LAST = AW'(CAPTURE_DEPTH - 1);

	corr_pkg::capture_state_e state;
	logic [AW-1:0] wptr;
	logic en_q;
	logic wr;

	corr_pkg::adc_raw_t mem [CAPTURE_DEPTH];

	assign wr = (state == corr_pkg::CAP_FILL) & capture_en & adc_valid;

	always_ff @(posedge data_clk_div) begin
		if (reset) begin
			state        <= corr_pkg::CAP_IDLE;
			wptr         <= '0;
			en_q         <= 1'b0;
			capture_done <= 1'b0;
		end else begin
			en_q         <= capture_en;
			capture_done <= capture_en && (state == corr_pkg::CAP_DONE);
			case (state)
				corr_pkg::CAP_IDLE: begin
					if (capture_en && !en_q) begin // arm on rising edge
						state <= corr_pkg::CAP_FILL;
						wptr  <= '0;
					end
				end
				corr_pkg::CAP_FILL: begin
					if (!capture_en)
						state <= corr_pkg::CAP_IDLE;
					else if (adc_valid) begin
						wptr <= wptr + 1'b1;
						if (wptr == LAST)
							state <= corr_pkg::CAP_DONE;
					end
				end
				corr_pkg::CAP_DONE: begin
					if (!capture_en)
						state <= corr_pkg::CAP_IDLE; // hold data until disarmed
				end
				default: state <= corr_pkg::CAP_IDLE;
			endcase
		end
	end

	always_ff @(posedge data_clk_div) begin
		if (wr)
			mem[wptr] <= adc_in;
		if (snap_re)
			snap_rdata <= mem[snap_raddr];
	end

endmodule

`default_nettype wire

// File: hdl/power_correlator.sv
/* zero-lag power correlator
   converts both channels to signed and sums x0*x0, x1*x1 and x0*x1 over acc_len samples */
`default_nettype none

module power_correlator (
	input  wire                        data_clk_div,
	input  wire                        reset,
	input  wire                        corr_en,
	input  wire [15:0]                 acc_len,
	input  wire corr_pkg::adc_raw_t    adc_in,
	input  wire                        adc_valid,
	output corr_pkg::corr_result_t     result,
	output logic                       result_valid
);

	localparam int W = corr_pkg::ACC_WIDTH;

	corr_pkg::sample_t x0;
	corr_pkg::sample_t x1;

	// stage 1, registered products
	logic signed [W-1:0] p_aa;
	logic signed [W-1:0] p_bb;
	logic signed [W-1:0] p_ab;
	logic p_valid;

	// stage 2, accumulators
	logic [W-1:0] acc_aa;
	logic [W-1:0] acc_bb;
	logic [W-1:0] acc_ab;
	logic [15:0] cnt;
	logic [15:0] last_cnt;
	logic group_end;

	// offset binary to two's complement
	assign x0 = {~adc_in.ch0[15], adc_in.ch0[14:2]};
	assign x1 = {~adc_in.ch1[15], adc_in.ch1[14:2]};

	assign last_cnt  = (acc_len == 16'd0) ? 16'd0 : acc_len - 16'd1; // 0 acts as 1
	assign group_end = corr_en & p_valid & (cnt >= last_cnt);

	always_ff @(posedge data_clk_div) begin
		p_aa <= x0 * x0;
		p_bb <= x1 * x1;
		p_ab <= x0 * x1;
	end

	always_ff @(posedge data_clk_div) begin
		if (reset)
			p_valid <= 1'b0;
		else
			p_valid <= adc_valid & corr_en;
	end

	always_ff @(posedge data_clk_div) begin
		if (reset) begin
			acc_aa       <= '0;
			acc_bb       <= '0;
			acc_ab       <= '0;
			cnt          <= '0;
			result_valid <= 1'b0;
		end else begin
			result_valid <= group_end;
			if (!corr_en || group_end) begin // drop partial group or restart
				acc_aa <= '0;
				acc_bb <= '0;
				acc_ab <= '0;
				cnt    <= '0;
			end else if (p_valid) begin
				acc_aa <= acc_aa + p_aa;
				acc_bb <= acc_bb + p_bb;
				acc_ab <= acc_ab + p_ab;
				cnt    <= cnt + 16'd1;
			end
		end
	end

	// final sums include the last product
	always_ff @(posedge data_clk_div) begin
		if (group_end) begin
			result.aa <= acc_aa + p_aa;
			result.bb <= acc_bb + p_bb;
			result.ab <= acc_ab + p_ab;
		end
	end

endmodule

`default_nettype wire

// File: hdl/result_buffer.sv
/* result buffer
   wrapping store of correlator results, read as aa, bb, ab words over apb */
`default_nettype none

module result_buffer #(
	parameter int RESULT_DEPTH = 16
) (
	input  wire                                 data_clk_div,
	input  wire                                 reset,
	input  wire corr_pkg::corr_result_t         result,
	input  wire                                 result_valid,
	output logic [7:0]                          result_count,
	input  wire [$clog2(RESULT_DEPTH)+1:0]      res_raddr,
	input  wire                                 res_re,
	output logic [31:0]                         res_rdata
);

	localparam int EW = $clog2(RESULT_DEPTH);

	corr_pkg::corr_result_t mem [RESULT_DEPTH];
	logic [EW-1:0] wptr; // wraps at RESULT_DEPTH
	corr_pkg::corr_result_t rd_entry;

	always_ff @(posedge data_clk_div) begin
		if (reset) begin
			wptr         <= '0;
			result_count <= '0;
		end else if (result_valid) begin
			wptr <= wptr + 1'b1;
			if (result_count != 8'hff)
				result_count <= result_count + 8'd1;
		end
	end

	assign rd_entry = mem[res_raddr[EW+1:2]];

	always_ff @(posedge data_clk_div) begin
		if (result_valid)
			mem[wptr] <= result;
		if (res_re) begin
			case (res_raddr[1:0])
				2'd0:    res_rdata <= rd_entry.aa;
				2'd1:    res_rdata <= rd_entry.bb;
				2'd2:    res_rdata <= rd_entry.ab;
				default: res_rdata <= '0; // unused word of the entry
			endcase
		end
	end

endmodule

`default_nettype wire

// File: hdl/corr_top.sv
/* correlator top level
   ties the apb register block, snapshot capture, correlator and result buffer together */
`default_nettype none

module corr_top #(
	parameter int CAPTURE_DEPTH = 256,
	parameter int RESULT_DEPTH  = 16
) (
	input  wire                       data_clk_div,
	input  wire                       reset,
	input  wire corr_pkg::adc_raw_t   adc_in,
	input  wire                       adc_valid,
	input  wire corr_pkg::apb_req_t   apb_req,
	output corr_pkg::apb_rsp_t        apb_rsp
);

	localparam int SNAP_AW = $clog2(CAPTURE_DEPTH);
	localparam int RES_AW  = $clog2(RESULT_DEPTH) + 2; // entry index plus word select

	corr_pkg::ctrl_t ctrl;
	logic capture_done;
	logic [7:0] result_count;

	logic [SNAP_AW-1:0] snap_raddr;
	logic snap_re;
	corr_pkg::adc_raw_t snap_rdata;

	logic [RES_AW-1:0] res_raddr;
	logic res_re;
	logic [31:0] res_rdata;

	corr_pkg::corr_result_t result;
	logic result_valid;

	apb_regs #(
		.CAPTURE_DEPTH(CAPTURE_DEPTH),
		.RESULT_DEPTH (RESULT_DEPTH)
	) apb_regs_inst (
		.data_clk_div (data_clk_div),
		.reset        (reset),
		.apb_req      (apb_req),
		.apb_rsp      (apb_rsp),
		.ctrl         (ctrl),
		.capture_done (capture_done),
		.result_count (result_count),
		.snap_raddr   (snap_raddr),
		.snap_re      (snap_re),
		.snap_rdata   (snap_rdata),
		.res_raddr    (res_raddr),
		.res_re       (res_re),
		.res_rdata    (res_rdata)
	);

	snapshot_capture #(
		.CAPTURE_DEPTH(CAPTURE_DEPTH)
	) snapshot_capture_inst (
		.data_clk_div (data_clk_div),
		.reset        (reset),
		.capture_en   (ctrl.capture_en),
		.adc_in       (adc_in),
		.adc_valid    (adc_valid),
		.capture_done (capture_done),
		.snap_raddr   (snap_raddr),
		.snap_re      (snap_re),
		.snap_rdata   (snap_rdata)
	);

	power_correlator power_correlator_inst (
		.data_clk_div (data_clk_div),
		.reset        (reset),
		.corr_en      (ctrl.corr_en),
		.acc_len      (ctrl.acc_len),
		.adc_in       (adc_in),
		.adc_valid    (adc_valid),
		.result       (result),
		.result_valid (result_valid)
	);

	result_buffer #(
		.RESULT_DEPTH(RESULT_DEPTH)
	) result_buffer_inst (
		.data_clk_div (data_clk_div),
		.reset        (reset),
		.result       (result),
		.result_valid (result_valid),
		.result_count (result_count),
		.res_raddr    (res_raddr),
		.res_re       (res_re),
		.res_rdata    (res_rdata)
	);

endmodule

`default_nettype wire

// File: tests/tb_corr_top.sv
/* testbench for corr_top
   random adc stream checked against a reference model over apb */
`default_nettype none

module tb_corr_top;

	localparam int CAPTURE_DEPTH = 256;
	localparam int RESULT_DEPTH  = 16;
	localparam int APB_TIMEOUT   = 10;
	localparam int POLL_LIMIT    = 50;

	logic data_clk_div;
	logic reset;
	corr_pkg::adc_raw_t adc_in;
	logic adc_valid;
	corr_pkg::apb_req_t apb_req;
	corr_pkg::apb_rsp_t apb_rsp;

	logic [31:0] seed = 32'd15;
	int errors;
	int checks;
	int total; // results expected since reset
	corr_pkg::adc_raw_t sent [$];
	corr_pkg::corr_result_t model_buf [RESULT_DEPTH];

	corr_top #(
		.CAPTURE_DEPTH(CAPTURE_DEPTH),
		.RESULT_DEPTH (RESULT_DEPTH)
	) uut (
		.data_clk_div (data_clk_div),
		.reset        (reset),
		.adc_in       (adc_in),
		.adc_valid    (adc_valid),
		.apb_req      (apb_req),
		.apb_rsp      (apb_rsp)
	);

	initial begin
		data_clk_div = 1'b0;
		forever #20 data_clk_div = ~data_clk_div;
	end

	function automatic logic [15:0] rand16();
		seed = seed * 32'd1103515245 + 32'd12345;
		return seed[31:16];
	endfunction

	// offset binary, mid code is zero
	function automatic int to_signed(logic [15:0] raw);
		return int'(raw[15:2]) - 8192;
	endfunction

	task automatic check_eq(string name, logic [31:0] got, logic [31:0] exp);
		checks++;
		assert (got === exp) else begin
			$display("FAIL %s got %h expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic abort_run(string why);
		$display("%s", why);
		$display("checks %0d, errors %0d", checks, errors);
		$display("CHECKS FAILED");
		$finish;
	endtask

	task automatic apb_xfer(input logic write, input logic [11:0] addr,
			input logic [31:0] wdata, output logic [31:0] rdata, output logic err);
		int tries;
		int exp_waits;
		// buffer reads hold pready low for one access cycle
		exp_waits = (!write && addr[1:0] == 2'b00 &&
			(addr[11:10] == 2'b01 || addr[11:10] == 2'b10)) ? 1 : 0;
		@(negedge data_clk_div);
		apb_req.psel    = 1'b1; // setup phase
		apb_req.penable = 1'b0;
		apb_req.pwrite  = write;
		apb_req.paddr   = addr;
		apb_req.pwdata  = wdata;
		@(negedge data_clk_div);
		apb_req.penable = 1'b1;
		tries = 0;
		#1;
		while (!apb_rsp.pready && tries < APB_TIMEOUT) begin
			@(negedge data_clk_div);
			#1;
			tries++;
		end
		if (!apb_rsp.pready) begin
			abort_run($sformatf("no pready from the DUT for address %h", addr));
		end else begin
			check_eq($sformatf("pready wait states %h", addr), 32'(tries), 32'(exp_waits));
			rdata = apb_rsp.prdata;
			err   = apb_rsp.pslverr;
			@(negedge data_clk_div); // access completes at the edge before this
			apb_req.psel    = 1'b0;
			apb_req.penable = 1'b0;
		end
	endtask

	task automatic apb_write(logic [11:0] addr, logic [31:0] data, logic exp_err);
		logic [31:0] rd;
		logic err;
		apb_xfer(1'b1, addr, data, rd, err);
		check_eq($sformatf("pslverr write %h", addr), 32'(err), 32'(exp_err));
	endtask

	task automatic apb_read(logic [11:0] addr, logic exp_err, output logic [31:0] data);
		logic err;
		apb_xfer(1'b0, addr, 32'd0, data, err);
		check_eq($sformatf("pslverr read %h", addr), 32'(err), 32'(exp_err));
	endtask

	task automatic read_check(logic [11:0] addr, string name, logic [31:0] exp);
		logic [31:0] rd;
		apb_read(addr, 1'b0, rd);
		check_eq(name, rd, exp);
	endtask

	task automatic wait_status(logic [31:0] mask, logic [31:0] value, string what);
		logic [31:0] st;
		int polls;
		polls = 0;
		apb_read(12'h008, 1'b0, st);
		while ((st & mask) != value && polls < POLL_LIMIT) begin
			apb_read(12'h008, 1'b0, st);
			polls++;
		end
		if ((st & mask) != value)
			abort_run(what);
	endtask

	// n valid pairs with random idle gaps
	task automatic drive_samples(int n);
		corr_pkg::adc_raw_t s;
		for (int i = 0; i < n; i++) begin
			@(negedge data_clk_div);
			if ((rand16() & 16'h3) == 16'h0) begin
				adc_valid = 1'b0;
				@(negedge data_clk_div);
			end
			s.ch0     = rand16();
			s.ch1     = rand16();
			adc_in    = s;
			adc_valid = 1'b1;
			sent.push_back(s);
		end
		@(negedge data_clk_div);
		adc_valid = 1'b0;
	endtask

	task automatic run_groups(int n_groups, int n_len);
		corr_pkg::corr_result_t r;
		corr_pkg::adc_raw_t s;
		int x0;
		int x1;
		sent.delete();
		drive_samples(n_groups * n_len);
		for (int g = 0; g < n_groups; g++) begin
			r = '0;
			for (int i = 0; i < n_len; i++) begin
				s  = sent[g * n_len + i];
				x0 = to_signed(s.ch0);
				x1 = to_signed(s.ch1);
				r.aa = r.aa + 32'(x0 * x0); // wraps mod 2**32
				r.bb = r.bb + 32'(x1 * x1);
				r.ab = r.ab + 32'(x0 * x1);
			end
			model_buf[total % RESULT_DEPTH] = r;
			total++;
		end
	endtask

	task automatic check_results();
		int n;
		wait_status(32'h0000ff00, 32'(total) << 8, "result count never reached its target");
		read_check(12'h008, "status", 32'(total) << 8);
		n = (total < RESULT_DEPTH) ? total : RESULT_DEPTH;
		for (int e = 0; e < n; e++) begin
			read_check(12'(32'h800 + 16 * e), $sformatf("result[%0d].aa", e), model_buf[e].aa);
			read_check(12'(32'h804 + 16 * e), $sformatf("result[%0d].bb", e), model_buf[e].bb);
			read_check(12'(32'h808 + 16 * e), $sformatf("result[%0d].ab", e), model_buf[e].ab);
		end
	endtask

	initial begin
		logic [31:0] rd;
		int n_len;
		errors    = 0;
		checks    = 0;
		total     = 0;
		reset     = 1'b1;
		adc_in    = '0;
		adc_valid = 1'b0;
		apb_req   = '0;
		repeat (3) @(posedge data_clk_div);
		@(negedge data_clk_div);
		reset = 1'b0;

		read_check(12'h000, "ctrl", 32'd0);
		read_check(12'h008, "status", 32'd0);
		read_check(12'h004, "acc_len", 32'd1);

		apb_write(12'h004, 32'h00001234, 1'b0);
		read_check(12'h004, "acc_len", 32'h00001234);
		apb_write(12'h000, 32'hffffffff, 1'b0);
		read_check(12'h000, "ctrl", 32'd3); // only two bits exist
		apb_write(12'h000, 32'd0, 1'b0);
		apb_read(12'h00c, 1'b1, rd);
		apb_write(12'hc00, 32'hffffffff, 1'b1);
		apb_write(12'h008, 32'hffffffff, 1'b1);
		read_check(12'h000, "ctrl", 32'd0);
		read_check(12'h004, "acc_len", 32'h00001234);
		read_check(12'h008, "status", 32'd0);

		// snapshot of the first CAPTURE_DEPTH pairs after arming
		sent.delete();
		apb_write(12'h000, 32'd1, 1'b0);
		drive_samples(CAPTURE_DEPTH + 12);
		wait_status(32'd1, 32'd1, "capture done never set");
		for (int i = 0; i < CAPTURE_DEPTH; i++)
			read_check(12'(32'h400 + 4 * i), $sformatf("snapshot[%0d]", i), sent[i]);
		apb_write(12'h400, 32'h5a5a5a5a, 1'b1); // buffer is read only
		read_check(12'h400, "snapshot[0]", sent[0]);
		apb_write(12'h000, 32'd0, 1'b0);

		n_len = int'(rand16() & 16'h3f) + 1;
		apb_write(12'h004, 32'(n_len), 1'b0);
		apb_write(12'h000, 32'd2, 1'b0);
		run_groups(3, n_len);
		check_results();
		apb_write(12'h800, 32'ha5a5a5a5, 1'b1);
		read_check(12'h800, "result[0].aa", model_buf[0].aa);

		run_groups(RESULT_DEPTH, n_len); // pointer wraps past entry 0
		check_results();

		// partial group dropped when corr_en clears
		n_len = int'(rand16() & 16'h1f) + 2;
		apb_write(12'h004, 32'(n_len), 1'b0);
		sent.delete();
		drive_samples(n_len - 1);
		apb_write(12'h000, 32'd0, 1'b0);
		apb_write(12'h000, 32'd2, 1'b0);
		run_groups(2, n_len);
		check_results();

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: corr_top.f
hdl/corr_pkg.sv
hdl/apb_regs.sv
hdl/snapshot_capture.sv
hdl/power_correlator.sv
hdl/result_buffer.sv
hdl/corr_top.sv
tests/tb_corr_top.sv

// File: Makefile
# Verilator build and run of the correlator testbench
VERILATOR ?= verilator
TOP       ?= tb_corr_top
FILELIST  ?= corr_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= ALL CHECKS PASSED
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and search $(LOG) for the pass message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   list these targets"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) && echo "test passed" || (echo "test failed"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
